// ==== mem_geom_pkg.sv ====
`default_nettype none

package mem_geom_pkg;

  // Bank count and bank index width
  parameter int NUM_VBNK = 8;
  parameter int BIT_VBNK = 3;

  // Rows per bank
  parameter int NUM_VROW = 16;
  parameter int BIT_VROW = 4;

  // Physical address is bank on top of row
  parameter int BIT_PADR = BIT_VBNK + BIT_VROW;

  // One word per bank
  parameter int WIDTH = 16;

endpackage

`default_nettype wire

// ==== mem_port_pkg.sv ====
`default_nettype none

package mem_port_pkg;

  import mem_geom_pkg::*;

  typedef logic [WIDTH-1:0] data_t;

  typedef logic [BIT_VBNK-1:0] bank_t;

  typedef logic [BIT_VROW-1:0] row_t;

  // Flat address or bank/row pair
  typedef union packed {
    logic [BIT_PADR-1:0] flat;
    struct packed {
      bank_t bank;
      row_t  row;
    } br;
  } padr_u;

endpackage

`default_nettype wire

// ==== bank_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bank_if
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
();

  // Write command per bank
  logic [NUM_VBNK-1:0] wr_en;
  row_t                wr_row  [NUM_VBNK];
  data_t               wr_data [NUM_VBNK];

  // Read command and returned word per bank
  logic [NUM_VBNK-1:0] rd_en;
  row_t                rd_row  [NUM_VBNK];
  data_t               rd_data [NUM_VBNK];

  modport write_side (
    output wr_en,
    output wr_row,
    output wr_data
  );

  modport read_side (
    output rd_en,
    output rd_row,
    input  rd_data
  );

  modport array (
    input  wr_en,
    input  wr_row,
    input  wr_data,
    input  rd_en,
    input  rd_row,
    output rd_data
  );

endinterface

`default_nettype wire

// ==== mrpnwp_write_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrpnwp_write_path
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
#(
  parameter int NUM_WRPT = 2,
  parameter int NUM_CMDL = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_WRPT-1:0] wr_en,
  input  padr_u               wr_addr [NUM_WRPT],
  input  data_t               wr_data [NUM_WRPT],
  bank_if.write_side          bnk
);

  localparam int NUM_GRPC = NUM_VBNK / NUM_CMDL;

  logic [NUM_VBNK-1:0] dec_en;
  row_t                dec_row  [NUM_VBNK];
  data_t               dec_data [NUM_VBNK];

  logic [NUM_VBNK-1:0] en_q   [NUM_GRPC];
  row_t                row_q  [NUM_GRPC][NUM_VBNK];
  data_t               data_q [NUM_GRPC][NUM_VBNK];

  // Port to bank decode, later ports overwrite earlier ones
  always_comb begin
    for (int b = 0; b < NUM_VBNK; b++) begin
      dec_en[b]   = 1'b0;
      dec_row[b]  = '0;
      dec_data[b] = '0;
      for (int p = 0; p < NUM_WRPT; p++) begin
        if (wr_en[p] && (wr_addr[p].br.bank == bank_t'(b))) begin
          dec_en[b]   = 1'b1;
          dec_row[b]  = wr_addr[p].br.row;
          dec_data[b] = wr_data[p];
        end
      end
    end
  end

  // One stage per command group
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_GRPC; s++) begin
        en_q[s] <= '0;
      end
    end else begin
      en_q[0] <= dec_en;
      for (int s = 1; s < NUM_GRPC; s++) begin
        en_q[s] <= en_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    row_q[0]  <= dec_row;
    data_q[0] <= dec_data;
    for (int s = 1; s < NUM_GRPC; s++) begin
      row_q[s]  <= row_q[s-1];
      data_q[s] <= data_q[s-1];
    end
  end

  // Each bank taps the stage of its own group
  for (genvar b = 0; b < NUM_VBNK; b++) begin : g_bank
    localparam int GRP = b / NUM_CMDL;

    assign bnk.wr_en[b]   = en_q[GRP][b];
    assign bnk.wr_row[b]  = row_q[GRP][b];
    assign bnk.wr_data[b] = data_q[GRP][b];
  end

endmodule

`default_nettype wire

// ==== mrpnwp_read_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrpnwp_read_path
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
#(
  parameter int NUM_RDPT   = 2,
  parameter int NUM_CMDL   = 2,
  parameter int SRAM_DELAY = 1
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_RDPT-1:0] rd_en,
  input  padr_u               rd_addr [NUM_RDPT],
  bank_if.read_side           bnk,
  output logic [NUM_RDPT-1:0] rd_vld,
  output padr_u               rd_padr [NUM_RDPT],
  output data_t               rd_dout [NUM_RDPT]
);

  localparam int NUM_GRPC   = NUM_VBNK / NUM_CMDL;
  localparam int RD_LATENCY = 1 + SRAM_DELAY + NUM_GRPC;

  logic [NUM_VBNK-1:0] dec_en;
  row_t                dec_row [NUM_VBNK];
  logic [NUM_VBNK-1:0] dec_sel [NUM_RDPT];

  logic [NUM_VBNK-1:0] cmd_en_q  [NUM_GRPC];
  row_t                cmd_row_q [NUM_GRPC][NUM_VBNK];

  // Port select per bank, aligned later with each bank's word
  logic [NUM_VBNK-1:0] sel_q [RD_LATENCY][NUM_RDPT];

  logic [NUM_RDPT-1:0] vld_q  [RD_LATENCY+1];
  padr_u               padr_q [RD_LATENCY+1][NUM_RDPT];

  // Collection chain, one link per bank plus the seed
  data_t link [NUM_RDPT][NUM_VBNK+1];

  always_comb begin
    for (int b = 0; b < NUM_VBNK; b++) begin
      dec_en[b]  = 1'b0;
      dec_row[b] = '0;
      for (int p = 0; p < NUM_RDPT; p++) begin
        dec_sel[p][b] = rd_en[p] && (rd_addr[p].br.bank == bank_t'(b));
        // Highest port picks the row
        if (dec_sel[p][b]) begin
          dec_en[b]  = 1'b1;
          dec_row[b] = rd_addr[p].br.row;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_GRPC; s++) begin
        cmd_en_q[s] <= '0;
      end
    end else begin
      cmd_en_q[0] <= dec_en;
      for (int s = 1; s < NUM_GRPC; s++) begin
        cmd_en_q[s] <= cmd_en_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    cmd_row_q[0] <= dec_row;
    for (int s = 1; s < NUM_GRPC; s++) begin
      cmd_row_q[s] <= cmd_row_q[s-1];
    end
    sel_q[0] <= dec_sel;
    for (int s = 1; s < RD_LATENCY; s++) begin
      sel_q[s] <= sel_q[s-1];
    end
  end

  // Valid and address follow the read to the output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s <= RD_LATENCY; s++) begin
        vld_q[s] <= '0;
      end
    end else begin
      vld_q[0] <= rd_en;
      for (int s = 1; s <= RD_LATENCY; s++) begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    padr_q[0] <= rd_addr;
    for (int s = 1; s <= RD_LATENCY; s++) begin
      padr_q[s] <= padr_q[s-1];
    end
  end

  assign rd_vld  = vld_q[RD_LATENCY];
  assign rd_padr = padr_q[RD_LATENCY];

  for (genvar b = 0; b < NUM_VBNK; b++) begin : g_cmd
    assign bnk.rd_en[b]  = cmd_en_q[b / NUM_CMDL][b];
    assign bnk.rd_row[b] = cmd_row_q[b / NUM_CMDL][b];
  end

  for (genvar p = 0; p < NUM_RDPT; p++) begin : g_port
    assign link[p][0] = '0;

    for (genvar b = 0; b < NUM_VBNK; b++) begin : g_bank
      // Word of a group g bank shows up g+1+SRAM_DELAY edges after the read
      localparam int SEL_STAGE = b / NUM_CMDL + 1 + SRAM_DELAY;

      data_t pick;

      assign pick = sel_q[SEL_STAGE][p][b] ? bnk.rd_data[b] : link[p][b];

      if ((b % NUM_CMDL) == (NUM_CMDL - 1)) begin : g_reg
        always_ff @(posedge clk) begin
          link[p][b+1] <= pick;
        end
      end else begin : g_pass
        assign link[p][b+1] = pick;
      end
    end

    assign rd_dout[p] = link[p][NUM_VBNK];
  end

endmodule

`default_nettype wire

// ==== mrpnwp_bank_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrpnwp_bank_array
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
#(
  parameter int SRAM_DELAY = 1
) (
  input  logic   clk,
  bank_if.array  bnk
);

  data_t mem [NUM_VBNK][NUM_VROW];

  // Capture register followed by SRAM_DELAY output stages
  data_t rd_pipe [NUM_VBNK][SRAM_DELAY+1];

  for (genvar b = 0; b < NUM_VBNK; b++) begin : g_bank

    // Read samples the old word when a write hits the same row
    always_ff @(posedge clk) begin
      if (bnk.rd_en[b]) begin
        rd_pipe[b][0] <= mem[b][bnk.rd_row[b]];
      end
      for (int s = 1; s <= SRAM_DELAY; s++) begin
        rd_pipe[b][s] <= rd_pipe[b][s-1];
      end
    end

    always_ff @(posedge clk) begin
      if (bnk.wr_en[b]) begin
        mem[b][bnk.wr_row[b]] <= bnk.wr_data[b];
      end
    end

    assign bnk.rd_data[b] = rd_pipe[b][SRAM_DELAY];
  end

endmodule

`default_nettype wire

// ==== mrpnwp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrpnwp_top
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
#(
  parameter int NUM_WRPT   = 2,
  parameter int NUM_RDPT   = 2,
  parameter int NUM_CMDL   = 2,
  parameter int SRAM_DELAY = 1
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_WRPT-1:0] wr_en,
  input  logic [BIT_PADR-1:0] wr_addr [NUM_WRPT],
  input  data_t               wr_data [NUM_WRPT],
  input  logic [NUM_RDPT-1:0] rd_en,
  input  logic [BIT_PADR-1:0] rd_addr [NUM_RDPT],
  output logic [NUM_RDPT-1:0] rd_vld,
  output logic [BIT_PADR-1:0] rd_padr [NUM_RDPT],
  output data_t               rd_dout [NUM_RDPT]
);

  padr_u wr_padr     [NUM_WRPT];
  padr_u rd_padr_in  [NUM_RDPT];
  padr_u rd_padr_out [NUM_RDPT];

  // Flat addresses at the pins
  for (genvar p = 0; p < NUM_WRPT; p++) begin : g_wr
    assign wr_padr[p].flat = wr_addr[p];
  end

  for (genvar p = 0; p < NUM_RDPT; p++) begin : g_rd
    assign rd_padr_in[p].flat = rd_addr[p];
    assign rd_padr[p]         = rd_padr_out[p].flat;
  end

  bank_if bnk ();

  mrpnwp_write_path #(
    .NUM_WRPT (NUM_WRPT),
    .NUM_CMDL (NUM_CMDL)
  ) u_write_path (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_padr),
    .wr_data (wr_data),
    .bnk     (bnk.write_side)
  );

  mrpnwp_read_path #(
    .NUM_RDPT   (NUM_RDPT),
    .NUM_CMDL   (NUM_CMDL),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_read_path (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_en   (rd_en),
    .rd_addr (rd_padr_in),
    .bnk     (bnk.read_side),
    .rd_vld  (rd_vld),
    .rd_padr (rd_padr_out),
    .rd_dout (rd_dout)
  );

  mrpnwp_bank_array #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_bank_array (
    .clk (clk),
    .bnk (bnk.array)
  );

endmodule

`default_nettype wire

// ==== tb_mrpnwp.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mrpnwp
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
();

  localparam int NUM_WRPT   = 2;
  localparam int NUM_RDPT   = 2;
  localparam int NUM_CMDL   = 2;
  localparam int SRAM_DELAY = 1;
  localparam int RD_LATENCY = 1 + SRAM_DELAY + NUM_VBNK / NUM_CMDL;
  localparam int NUM_ADDR   = NUM_VBNK * NUM_VROW;
  localparam int CLK_PERIOD = 10;

  // Cycle budget of reset and six tests with their drains plus a margin
  localparam int DRAIN_CYCLES = RD_LATENCY + 3;
  localparam int TEST_CYCLES  = 4 + (RD_LATENCY + 2) + 2 * (3 + DRAIN_CYCLES)
                                + (NUM_ADDR / 2 + 40 + DRAIN_CYCLES) + 2 * (4 + DRAIN_CYCLES);
  localparam int WATCHDOG_NS  = (TEST_CYCLES + 200) * CLK_PERIOD;

  typedef logic [BIT_PADR-1:0] addr_t;

  typedef struct {
    int    due;
    addr_t padr;
    data_t data;
  } exp_t;

  logic                clk;
  logic                rst_n;
  logic [NUM_WRPT-1:0] wr_en;
  addr_t               wr_addr [NUM_WRPT];
  data_t               wr_data [NUM_WRPT];
  logic [NUM_RDPT-1:0] rd_en;
  addr_t               rd_addr [NUM_RDPT];
  logic [NUM_RDPT-1:0] rd_vld;
  addr_t               rd_padr [NUM_RDPT];
  data_t               rd_dout [NUM_RDPT];

  int edge_cnt     = 0;
  int errors       = 0;
  int tests_run    = 0;
  int failed_tests = 0;

  // Reference contents and expected results per read port
  data_t model [addr_t];
  exp_t  exp_q [NUM_RDPT][$];

  mrpnwp_top #(
    .NUM_WRPT   (NUM_WRPT),
    .NUM_RDPT   (NUM_RDPT),
    .NUM_CMDL   (NUM_CMDL),
    .SRAM_DELAY (SRAM_DELAY)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_vld  (rd_vld),
    .rd_padr (rd_padr),
    .rd_dout (rd_dout)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic bank_t bank_of(addr_t a);
    return a[BIT_PADR-1 -: BIT_VBNK];
  endfunction

  function automatic data_t fill_word(addr_t a);
    return data_t'(a * 16'h9e37) ^ 16'h5ac3;
  endfunction

  task automatic report_mismatch(string sig, logic [31:0] expected, logic [31:0] actual);
    $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, sig, expected, actual);
    errors++;
  endtask

  task automatic report_failure(string what);
    $display("ERROR time=%0t %s", $time, what);
    errors++;
  endtask

  task automatic clear_inputs();
    wr_en = '0;
    rd_en = '0;
    for (int p = 0; p < NUM_WRPT; p++) begin
      wr_addr[p] = '0;
      wr_data[p] = '0;
    end
    for (int p = 0; p < NUM_RDPT; p++) begin
      rd_addr[p] = '0;
    end
  endtask

  task automatic write_word(int port, addr_t a, data_t d);
    wr_en[port]   = 1'b1;
    wr_addr[port] = a;
    wr_data[port] = d;
  endtask

  task automatic read_word(int port, addr_t a);
    rd_en[port]   = 1'b1;
    rd_addr[port] = a;
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
    wr_en = '0;
    rd_en = '0;
  endtask

  task automatic drain();
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  // Same-cycle write and read of one address followed by a read one cycle later
  task automatic ordering_case(addr_t a);
    write_word(0, a, ~model[a]);
    read_word(1, a);
    tick();
    read_word(0, a);
    tick();
  endtask

  // Reads see the contents before this edge's writes
  always @(posedge clk) begin
    exp_t  e;
    addr_t src;
    logic  win;
    edge_cnt = edge_cnt + 1;
    if (rst_n) begin
      for (int p = 0; p < NUM_RDPT; p++) begin
        if (rd_en[p]) begin
          src = rd_addr[p];
          // Highest port on a shared bank picks the row
          for (int q = p + 1; q < NUM_RDPT; q++) begin
            if (rd_en[q] && bank_of(rd_addr[q]) == bank_of(rd_addr[p])) begin
              src = rd_addr[q];
            end
          end
          if (!model.exists(src)) begin
            report_failure($sformatf("read of address %h that was never written", src));
          end
          e.due  = edge_cnt + RD_LATENCY;
          e.padr = rd_addr[p];
          e.data = model[src];
          exp_q[p].push_back(e);
        end
      end
      for (int p = 0; p < NUM_WRPT; p++) begin
        win = wr_en[p];
        for (int q = p + 1; q < NUM_WRPT; q++) begin
          if (wr_en[q] && bank_of(wr_addr[q]) == bank_of(wr_addr[p])) begin
            win = 1'b0;
          end
        end
        if (win) begin
          model[wr_addr[p]] = wr_data[p];
        end
      end
    end
  end

  // Outputs are compared mid-cycle
  always @(negedge clk) begin
    exp_t head;
    for (int p = 0; p < NUM_RDPT; p++) begin
      if (exp_q[p].size() != 0 && exp_q[p][0].due == edge_cnt) begin
        head = exp_q[p].pop_front();
        assert (rd_vld[p] === 1'b1)
          else report_mismatch($sformatf("rd_vld[%0d]", p), 32'd1, 32'(rd_vld[p]));
        assert (rd_padr[p] === head.padr)
          else report_mismatch($sformatf("rd_padr[%0d]", p), 32'(head.padr), 32'(rd_padr[p]));
        assert (rd_dout[p] === head.data)
          else report_mismatch($sformatf("rd_dout[%0d]", p), 32'(head.data), 32'(rd_dout[p]));
      end else begin
        assert (rd_vld[p] === 1'b0)
          else report_mismatch($sformatf("rd_vld[%0d]", p), 32'd0, 32'(rd_vld[p]));
      end
    end
  end

  // A valid needs a read accepted out of reset RD_LATENCY cycles before
  assert property (@(posedge clk)
    (rd_vld & ~$past(rd_en & {NUM_RDPT{rst_n}}, RD_LATENCY + 1)) == '0)
    else report_failure($sformatf("rd_vld high without a read accepted %0d cycles before",
                                  RD_LATENCY));

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  initial begin
    int err0;
    void'($urandom(32'hf4a4));
    clear_inputs();
    rst_n = 1'b0;

    // Reads offered during reset must never come back
    err0 = errors;
    rd_en = '1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    rd_en = '0;
    repeat (RD_LATENCY + 2) tick();
    finish_test("reset", err0);

    err0 = errors;
    write_word(0, 7'h25, data_t'($urandom));
    tick();
    tick();
    read_word(0, 7'h25);
    tick();
    drain();
    finish_test("write_read_back", err0);

    err0 = errors;
    write_word(0, 7'h13, data_t'($urandom));
    write_word(1, 7'h62, data_t'($urandom));
    tick();
    read_word(0, 7'h13);
    read_word(1, 7'h62);
    tick();
    drain();
    finish_test("parallel_ports", err0);

    // Upper half goes to other banks than the lower half
    err0 = errors;
    for (int i = 0; i < NUM_ADDR / 2; i++) begin
      write_word(0, addr_t'(i), fill_word(addr_t'(i)));
      write_word(1, addr_t'(i + NUM_ADDR / 2), fill_word(addr_t'(i + NUM_ADDR / 2)));
      tick();
    end
    repeat (40) begin
      read_word(0, addr_t'($urandom_range(NUM_ADDR - 1, 0)));
      read_word(1, addr_t'($urandom_range(NUM_ADDR - 1, 0)));
      tick();
    end
    drain();
    finish_test("back_to_back_reads", err0);

    err0 = errors;
    ordering_case(7'h0a);
    ordering_case(7'h75);
    drain();
    finish_test("same_cycle_ordering", err0);

    err0 = errors;
    write_word(0, 7'h4b, data_t'($urandom));
    write_word(1, 7'h4b, data_t'($urandom));
    tick();
    write_word(0, 7'h51, data_t'($urandom));
    write_word(1, 7'h5e, data_t'($urandom));
    tick();
    read_word(0, 7'h4b);
    read_word(1, 7'h5e);
    tick();
    read_word(0, 7'h51);
    tick();
    drain();
    finish_test("write_conflict", err0);

    $display("summary: %0d tests run, %0d failing, %0d check errors",
             tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
mem_geom_pkg.sv
mem_port_pkg.sv
bank_if.sv
mrpnwp_write_path.sv
mrpnwp_read_path.sv
mrpnwp_bank_array.sv
mrpnwp_top.sv
tb_mrpnwp.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mrpnwp -f compile.f -o tb_mrpnwp \
  && ./obj_dir/tb_mrpnwp | tee /dev/stderr | grep -q "all tests passed" \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

exit 0
